// ==== kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

    // One held key as the keyboard reports it
    typedef struct packed {
        logic       ext;  // E0 prefixed
        logic [7:0] code; // Set 2 scan code
    } key_entry_t;

    // Level passed from the tracker to the mapper
    typedef struct packed {
        key_entry_t entry; // Current key or all zero
        logic       shift; // Either shift key held
        logic       caps;  // Caps lock active
    } key_state_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Prefix bytes
    localparam logic [7:0] SCAN_EXT   = 8'hE0;
    localparam logic [7:0] SCAN_BREAK = 8'hF0;

    // Modifier make codes
    localparam logic [7:0] SCAN_LSHIFT = 8'h12;
    localparam logic [7:0] SCAN_RSHIFT = 8'h59;
    localparam logic [7:0] SCAN_CAPS   = 8'h58;

    localparam int KEY_TABLE_DEPTH = 3; // Held key slots

    // Longest gap between ps2_clk falls inside a frame
    localparam int PS2_TIMEOUT_CYCLES = 5000;

endpackage

`default_nettype wire

// ==== ps2_rx.sv ====
`default_nettype none
`timescale 1ns/100ps

module ps2_rx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       scan_valid,
    output logic [7:0] scan_code,
    output logic       frame_err
);
    import kbd_pkg::*;

    localparam int TO_W = $clog2(PS2_TIMEOUT_CYCLES);

    logic [2:0]      clk_sync;    // Two sync stages plus edge history
    logic [1:0]      data_sync;
    logic            clk_fall;
    logic            bit_in;
    rx_state_t       state;
    logic [2:0]      bit_cnt;
    logic [7:0]      shift_q;
    logic            parity_q;    // XOR of data and parity bits
    logic            start_bad;
    logic [TO_W-1:0] timeout_cnt;
    logic            timed_out;

    assign clk_fall  = clk_sync[2] & ~clk_sync[1];
    assign bit_in    = data_sync[1];
    assign timed_out = (timeout_cnt == TO_W'(PS2_TIMEOUT_CYCLES - 1));
    assign scan_code = shift_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= 3'b111; // Idle lines float high
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // Counts cycles of a high clock while a frame is open
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timeout_cnt <= '0;
        end else if (state == RX_IDLE || clk_fall || !clk_sync[1]) begin
            timeout_cnt <= '0;
        end else begin
            timeout_cnt <= timeout_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            parity_q   <= 1'b0;
            start_bad  <= 1'b0;
            scan_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            scan_valid <= 1'b0;
            frame_err  <= 1'b0;
            if (timed_out) begin
                state <= RX_IDLE; // Stalled frame is dropped silently
            end else if (clk_fall) begin
                case (state)
                    RX_IDLE: begin
                        start_bad <= bit_in; // Start bit must be 0
                        parity_q  <= 1'b0;
                        bit_cnt   <= '0;
                        state     <= RX_DATA;
                    end
                    RX_DATA: begin
                        parity_q <= parity_q ^ bit_in;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        parity_q <= parity_q ^ bit_in;
                        state    <= RX_STOP;
                    end
                    RX_STOP: begin
                        if (bit_in && !start_bad && parity_q) begin
                            scan_valid <= 1'b1;
                        end else begin
                            frame_err <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (clk_fall && state == RX_DATA) begin
            shift_q <= {bit_in, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== key_tracker.sv ====
`default_nettype none
`timescale 1ns/100ps

module key_tracker (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                scan_valid,
    input  logic [7:0]          scan_code,
    output kbd_pkg::key_state_t key_state,
    output logic                key_event
);
    import kbd_pkg::*;

    localparam int IDX_W = $clog2(KEY_TABLE_DEPTH);

    key_entry_t       slot [KEY_TABLE_DEPTH]; // Zero means empty
    key_entry_t       entry_in;
    logic             pend_ext;
    logic             pend_brk;
    logic             lshift;
    logic             rshift;
    logic             caps_on;
    logic [IDX_W-1:0] wr_idx;   // Next slot to overwrite
    logic [IDX_W-1:0] cur_idx;
    logic [IDX_W-1:0] next_wr;
    logic [IDX_W-1:0] hit_idx;
    logic             hit;
    logic             is_lshift;
    logic             is_rshift;
    logic             is_caps;

    assign entry_in  = '{ext: pend_ext, code: scan_code};
    assign is_lshift = !pend_ext && scan_code == SCAN_LSHIFT;
    assign is_rshift = !pend_ext && scan_code == SCAN_RSHIFT;
    assign is_caps   = !pend_ext && scan_code == SCAN_CAPS;
    assign next_wr   = (wr_idx == IDX_W'(KEY_TABLE_DEPTH - 1)) ? '0 : wr_idx + 1'b1;

    // Lowest matching slot wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = KEY_TABLE_DEPTH - 1; i >= 0; i--) begin
            if (slot[i] == entry_in) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < KEY_TABLE_DEPTH; i++) begin
                slot[i] <= '0;
            end
            pend_ext  <= 1'b0;
            pend_brk  <= 1'b0;
            lshift    <= 1'b0;
            rshift    <= 1'b0;
            caps_on   <= 1'b0;
            wr_idx    <= '0;
            cur_idx   <= '0;
            key_event <= 1'b0;
        end else begin
            key_event <= 1'b0;
            if (scan_valid) begin
                if (scan_code == SCAN_EXT) begin
                    pend_ext <= 1'b1;
                end else if (scan_code == SCAN_BREAK) begin
                    pend_brk <= 1'b1;
                end else begin
                    pend_ext <= 1'b0;
                    pend_brk <= 1'b0;
                    if (pend_brk) begin
                        if (hit) begin
                            slot[hit_idx] <= '0; // Current entry may read empty now
                        end
                        if (is_lshift) lshift <= 1'b0;
                        if (is_rshift) rshift <= 1'b0;
                    end else begin
                        key_event <= 1'b1;
                        if (hit) begin
                            cur_idx <= hit_idx; // Typematic repeat
                        end else begin
                            slot[wr_idx] <= entry_in;
                            cur_idx      <= wr_idx;
                            wr_idx       <= next_wr;
                        end
                        if (is_lshift) lshift <= 1'b1;
                        if (is_rshift) rshift <= 1'b1;
                        if (is_caps && !hit) caps_on <= ~caps_on; // Held caps does not retoggle
                    end
                end
            end
        end
    end

    assign key_state = '{entry: slot[cur_idx], shift: lshift | rshift, caps: caps_on};

endmodule

`default_nettype wire

// ==== key_map.sv ====
`default_nettype none
`timescale 1ns/100ps

module key_map (
    input  logic                clk,
    input  logic                arst_n,
    input  kbd_pkg::key_state_t key_state,
    input  logic                key_event,
    output logic [7:0]          key,
    output logic                key_strobe
);
    import kbd_pkg::*;

    logic [7:0] key_next;
    logic [7:0] code;

    assign code = key_state.entry.code;

    always_comb begin
        key_next = 8'd0; // Unknown and empty entries
        if (key_state.entry.ext) begin
            case (code)
                8'h6b: key_next = 8'd130; // Left arrow
                8'h75: key_next = 8'd131; // Up arrow
                8'h74: key_next = 8'd132; // Right arrow
                8'h72: key_next = 8'd133; // Down arrow
                8'h6c: key_next = 8'd134; // Home
                8'h69: key_next = 8'd135; // End
                8'h7d: key_next = 8'd136; // Page up
                8'h7a: key_next = 8'd137; // Page down
                8'h70: key_next = 8'd138; // Insert
                8'h71: key_next = 8'd139; // Delete
                default: key_next = 8'd0;
            endcase
        end else if (key_state.shift != key_state.caps) begin
            case (code)
                8'h29: key_next = 8'd32;  // Space
                8'h16: key_next = 8'd33;
                8'h52: key_next = 8'd34;
                8'h26: key_next = 8'd35;
                8'h25: key_next = 8'd36;
                8'h2e: key_next = 8'd37;
                8'h3d: key_next = 8'd38;
                8'h46: key_next = 8'd40;
                8'h45: key_next = 8'd41;
                8'h3e: key_next = 8'd42;
                8'h55: key_next = 8'd43;
                8'h4c: key_next = 8'd58;
                8'h41: key_next = 8'd60;
                8'h49: key_next = 8'd62;
                8'h4a: key_next = 8'd63;
                8'h1e: key_next = 8'd64;
                8'h1c: key_next = 8'd65;  // Upper case letters start here
                8'h32: key_next = 8'd66;
                8'h21: key_next = 8'd67;
                8'h23: key_next = 8'd68;
                8'h24: key_next = 8'd69;
                8'h2b: key_next = 8'd70;
                8'h34: key_next = 8'd71;
                8'h33: key_next = 8'd72;
                8'h43: key_next = 8'd73;
                8'h3b: key_next = 8'd74;
                8'h42: key_next = 8'd75;
                8'h4b: key_next = 8'd76;
                8'h3a: key_next = 8'd77;
                8'h31: key_next = 8'd78;
                8'h44: key_next = 8'd79;
                8'h4d: key_next = 8'd80;
                8'h15: key_next = 8'd81;
                8'h2d: key_next = 8'd82;
                8'h1b: key_next = 8'd83;
                8'h2c: key_next = 8'd84;
                8'h3c: key_next = 8'd85;
                8'h2a: key_next = 8'd86;
                8'h1d: key_next = 8'd87;
                8'h22: key_next = 8'd88;
                8'h35: key_next = 8'd89;
                8'h1a: key_next = 8'd90;
                8'h36: key_next = 8'd94;
                8'h4e: key_next = 8'd95;
                8'h54: key_next = 8'd123;
                8'h5d: key_next = 8'd124;
                8'h5b: key_next = 8'd125;
                8'h0e: key_next = 8'd126;
                default: key_next = 8'd0;
            endcase
        end else begin
            case (code)
                8'h0d: key_next = 8'd9;   // Tab
                8'h29: key_next = 8'd32;  // Space
                8'h52: key_next = 8'd39;
                8'h7c: key_next = 8'd42;  // Keypad star
                8'h79: key_next = 8'd43;  // Keypad plus
                8'h41: key_next = 8'd44;
                8'h49: key_next = 8'd46;
                8'h71: key_next = 8'd46;  // Keypad dot
                8'h4e: key_next = 8'd45;
                8'h7b: key_next = 8'd45;  // Keypad minus
                8'h4a: key_next = 8'd47;
                8'h45: key_next = 8'd48;
                8'h70: key_next = 8'd48;  // Keypad digits mixed in below
                8'h16: key_next = 8'd49;
                8'h69: key_next = 8'd49;
                8'h1e: key_next = 8'd50;
                8'h72: key_next = 8'd50;
                8'h26: key_next = 8'd51;
                8'h7a: key_next = 8'd51;
                8'h25: key_next = 8'd52;
                8'h6b: key_next = 8'd52;
                8'h2e: key_next = 8'd53;
                8'h73: key_next = 8'd53;
                8'h36: key_next = 8'd54;
                8'h74: key_next = 8'd54;
                8'h3d: key_next = 8'd55;
                8'h6c: key_next = 8'd55;
                8'h3e: key_next = 8'd56;
                8'h75: key_next = 8'd56;
                8'h46: key_next = 8'd57;
                8'h7d: key_next = 8'd57;
                8'h4c: key_next = 8'd59;
                8'h55: key_next = 8'd61;
                8'h54: key_next = 8'd91;
                8'h5d: key_next = 8'd92;  // Backslash
                8'h5b: key_next = 8'd93;
                8'h0e: key_next = 8'd96;
                8'h1c: key_next = 8'd97;  // Lower case letters start here
                8'h32: key_next = 8'd98;
                8'h21: key_next = 8'd99;
                8'h23: key_next = 8'd100;
                8'h24: key_next = 8'd101;
                8'h2b: key_next = 8'd102;
                8'h34: key_next = 8'd103;
                8'h33: key_next = 8'd104;
                8'h43: key_next = 8'd105;
                8'h3b: key_next = 8'd106;
                8'h42: key_next = 8'd107;
                8'h4b: key_next = 8'd108;
                8'h3a: key_next = 8'd109;
                8'h31: key_next = 8'd110;
                8'h44: key_next = 8'd111;
                8'h4d: key_next = 8'd112;
                8'h15: key_next = 8'd113;
                8'h2d: key_next = 8'd114;
                8'h1b: key_next = 8'd115;
                8'h2c: key_next = 8'd116;
                8'h3c: key_next = 8'd117;
                8'h2a: key_next = 8'd118;
                8'h1d: key_next = 8'd119;
                8'h22: key_next = 8'd120;
                8'h35: key_next = 8'd121;
                8'h1a: key_next = 8'd122;
                8'h5a: key_next = 8'd128; // Enter
                8'h66: key_next = 8'd129; // Backspace
                8'h76: key_next = 8'd140; // Escape
                8'h05: key_next = 8'd141; // F1
                8'h06: key_next = 8'd142;
                8'h04: key_next = 8'd143;
                8'h0c: key_next = 8'd144;
                8'h03: key_next = 8'd145;
                8'h0b: key_next = 8'd146;
                8'h83: key_next = 8'd147; // F7 sits outside the usual range
                8'h0a: key_next = 8'd148;
                8'h01: key_next = 8'd149;
                8'h09: key_next = 8'd150;
                8'h78: key_next = 8'd151;
                8'h07: key_next = 8'd152; // F12
                default: key_next = 8'd0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key        <= 8'd0;
            key_strobe <= 1'b0;
        end else begin
            key        <= key_next;
            key_strobe <= key_event;
        end
    end

endmodule

`default_nettype wire

// ==== ps2_keyboard.sv ====
`default_nettype none
`timescale 1ns/100ps

module ps2_keyboard (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] key,
    output logic       key_strobe,
    output logic       frame_err
);
    import kbd_pkg::*;

    logic       scan_valid;
    logic [7:0] scan_code;
    key_state_t key_state;
    logic       key_event;

    ps2_rx u_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan_valid (scan_valid),
        .scan_code  (scan_code),
        .frame_err  (frame_err)
    );

    key_tracker u_tracker (
        .clk        (clk),
        .arst_n     (arst_n),
        .scan_valid (scan_valid),
        .scan_code  (scan_code),
        .key_state  (key_state),
        .key_event  (key_event)
    );

    key_map u_map (
        .clk        (clk),
        .arst_n     (arst_n),
        .key_state  (key_state),
        .key_event  (key_event),
        .key        (key),
        .key_strobe (key_strobe)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    localparam int HALF_PERIOD  = 10; // 20 ns period
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        #(2 * HALF_PERIOD * RESET_CYCLES);
        arst_n = 1'b1; // Lands on a falling edge
    end

endmodule

`default_nettype wire

// ==== tb_key_ref.svh ====
`ifndef TB_KEY_REF_SVH
`define TB_KEY_REF_SVH

// Set 2 code tables, first entry in the highest used byte
localparam logic [255:0] LETTER_CODES = 256'h1c322123_242b3433_433b424b_3a31444d_152d1b2c_3c2a1d22_351a;
localparam logic [255:0] DIGIT_CODES  = 256'h45161e26_252e363d_3e46;     // 0 to 9
localparam logic [255:0] KEYPAD_CODES = 256'h7069727a_6b73746c_757d;     // Keypad 0 to 9
localparam logic [255:0] FKEY_CODES   = 256'h0506040c_030b830a_01097807; // F1 to F12
localparam logic [255:0] EXT_CODES    = 256'h6b757472_6c697d7a_7071;     // Codes 130 to 139
localparam logic [79:0]  SHIFT_SYMS   = ")!@#$%^&*(";                  // Shifted 0 to 9

function automatic logic [7:0] table_entry(input logic [255:0] tab, input int n, input int i);
    return tab[8 * (n - 1 - i) +: 8];
endfunction

function automatic int find_code(input logic [255:0] tab, input int n, input logic [7:0] code);
    int idx;
    idx = -1;
    for (int i = n - 1; i >= 0; i--) begin
        if (table_entry(tab, n, i) == code) idx = i;
    end
    return idx;
endfunction

// Expected key register value for one held key
function automatic logic [7:0] ref_key(input logic ext, input logic [7:0] code,
                                       input logic shift, input logic caps);
    int         lt;
    int         dg;
    int         kp;
    int         fk;
    int         ex;
    logic       upper;
    logic [7:0] res;
    lt    = find_code(LETTER_CODES, 26, code);
    dg    = find_code(DIGIT_CODES, 10, code);
    kp    = find_code(KEYPAD_CODES, 10, code);
    fk    = find_code(FKEY_CODES, 12, code);
    ex    = find_code(EXT_CODES, 10, code);
    upper = shift ^ caps;
    res   = 8'd0;
    if (ext) begin
        if (ex >= 0) res = 8'(130 + ex);
    end else if (lt >= 0) begin
        res = upper ? 8'(65 + lt) : 8'(97 + lt);
    end else if (dg >= 0) begin
        res = upper ? SHIFT_SYMS[8 * (9 - dg) +: 8] : 8'(48 + dg);
    end else if (upper) begin
        res = 8'd0; // No keypad or control keys when shifted
    end else if (kp >= 0) begin
        res = 8'(48 + kp);
    end else if (fk >= 0) begin
        res = 8'(141 + fk);
    end else if (code == 8'h71) begin
        res = 8'd46; // Keypad dot
    end else if (code == 8'h5a) begin
        res = 8'd128;
    end else if (code == 8'h66) begin
        res = 8'd129;
    end else if (code == 8'h76) begin
        res = 8'd140;
    end
    return res;
endfunction

`endif

// ==== tb_ps2_keyboard.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_ps2_keyboard;
    import kbd_pkg::*;

    `include "tb_key_ref.svh"

    localparam int DRIVE_DLY    = 2;
    localparam int PS2_HALF     = 20;  // clk cycles per PS/2 clock phase
    localparam int SETTLE_LIMIT = 200;

    logic       clk;
    logic       arst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic [7:0] key;
    logic       key_strobe;
    logic       frame_err;

    logic [8:0] m_slot [KEY_TABLE_DEPTH]; // Model of the held-key table
    int         m_wr;
    int         m_cur;
    logic       m_lshift;
    logic       m_rshift;
    logic       m_caps;
    int         exp_strobes;
    int         exp_errs;
    int         strobe_cnt;
    int         err_cnt;
    int         seed;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ps2_keyboard dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .key        (key),
        .key_strobe (key_strobe),
        .frame_err  (frame_err)
    );

    // Counts output pulses
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            strobe_cnt <= 0;
            err_cnt    <= 0;
        end else begin
            if (key_strobe) strobe_cnt <= strobe_cnt + 1;
            if (frame_err) err_cnt <= err_cnt + 1;
        end
    end

    task automatic check_eq(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("Fail at time %0t: %s got %0d expected %0d", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic logic [10:0] make_frame(input logic [7:0] b, input logic bad_par,
                                               input logic bad_stop);
        return {~bad_stop, (~^b) ^ bad_par, b, 1'b0}; // Odd parity
    endfunction

    task automatic drive_frame(input logic [10:0] frame, input int nbits);
        for (int i = 0; i < nbits; i++) begin
            ps2_data = frame[i];
            tick(PS2_HALF / 2);
            ps2_clk = 1'b0;
            tick(PS2_HALF);
            ps2_clk = 1'b1;
            tick(PS2_HALF / 2);
        end
        ps2_data = 1'b1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        drive_frame(make_frame(b, 1'b0, 1'b0), 11);
    endtask

    // Waits for 10 quiet cycles on the line and the outputs
    task automatic settle();
        int         quiet;
        int         waited;
        logic [7:0] last;
        quiet  = 0;
        waited = 0;
        last   = key;
        while (quiet < 10 && waited < SETTLE_LIMIT) begin
            tick(1);
            waited++;
            if (!ps2_clk || key_strobe || frame_err || key != last) quiet = 0;
            else quiet++;
            last = key;
        end
        if (quiet < 10) begin
            $display("Timeout: DUT outputs did not settle within %0d cycles", SETTLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "Settle timeout");
        end
    endtask

    function automatic int model_find(input logic [8:0] e);
        int idx;
        idx = -1;
        for (int i = KEY_TABLE_DEPTH - 1; i >= 0; i--) begin
            if (m_slot[i] == e) idx = i;
        end
        return idx;
    endfunction

    task automatic model_make(input logic [8:0] e);
        int hit;
        hit = model_find(e);
        if (hit >= 0) begin
            m_cur = hit;
        end else begin
            m_slot[m_wr] = e;
            m_cur        = m_wr;
            m_wr         = (m_wr + 1) % KEY_TABLE_DEPTH; // Oldest goes next
        end
        if (e == {1'b0, SCAN_LSHIFT}) m_lshift = 1'b1;
        if (e == {1'b0, SCAN_RSHIFT}) m_rshift = 1'b1;
        if (e == {1'b0, SCAN_CAPS} && hit < 0) m_caps = ~m_caps;
        exp_strobes++;
    endtask

    task automatic model_break(input logic [8:0] e);
        int hit;
        hit = model_find(e);
        if (hit >= 0) m_slot[hit] = '0;
        if (e == {1'b0, SCAN_LSHIFT}) m_lshift = 1'b0;
        if (e == {1'b0, SCAN_RSHIFT}) m_rshift = 1'b0;
    endtask

    function automatic logic [7:0] expected_key();
        return ref_key(m_slot[m_cur][8], m_slot[m_cur][7:0], m_lshift | m_rshift, m_caps);
    endfunction

    task automatic key_press(input logic ext, input logic [7:0] code);
        if (ext) send_byte(SCAN_EXT);
        send_byte(code);
        model_make({ext, code});
        settle();
        check_eq(int'(key), int'(expected_key()), $sformatf("make %0b/%h", ext, code));
    endtask

    task automatic key_release(input logic ext, input logic [7:0] code);
        if (ext) send_byte(SCAN_EXT);
        send_byte(SCAN_BREAK);
        send_byte(code);
        model_break({ext, code});
        settle();
        check_eq(int'(key), int'(expected_key()), $sformatf("break %0b/%h", ext, code));
    endtask

    task automatic key_tap(input logic ext, input logic [7:0] code);
        key_press(ext, code);
        key_release(ext, code);
    endtask

    task automatic end_scenario(input string name);
        check_eq(strobe_cnt, exp_strobes, {name, ": key_strobe count"});
        check_eq(err_cnt, exp_errs, {name, ": frame_err count"});
    endtask

    initial begin
        int         n;
        int         r;
        int         idx;
        logic [7:0] code;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        seed        = 32'h75e5;
        m_wr        = 0;
        m_cur       = 0;
        m_lshift    = 1'b0;
        m_rshift    = 1'b0;
        m_caps      = 1'b0;
        exp_strobes = 0;
        exp_errs    = 0;
        for (int i = 0; i < KEY_TABLE_DEPTH; i++) begin
            m_slot[i] = '0;
        end
        n = 0;
        while (arst_n !== 1'b1 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("Reset was never released");
            $display("TEST FAILED");
            $fatal(1, "Reset timeout");
        end
        tick(5);
        check_eq(int'(key), 0, "key after reset");

        // Plain table
        for (int i = 0; i < 26; i++) key_tap(1'b0, table_entry(LETTER_CODES, 26, i));
        for (int i = 0; i < 10; i++) key_tap(1'b0, table_entry(DIGIT_CODES, 10, i));
        for (int i = 0; i < 12; i++) key_tap(1'b0, table_entry(FKEY_CODES, 12, i));
        key_tap(1'b0, 8'h5a);
        key_tap(1'b0, 8'h66);
        key_tap(1'b0, 8'h76);
        end_scenario("plain keys");

        key_press(1'b0, SCAN_LSHIFT);
        key_tap(1'b0, 8'h1c);
        key_release(1'b0, SCAN_LSHIFT);
        key_press(1'b0, SCAN_RSHIFT);
        key_press(1'b0, 8'h32);
        key_release(1'b0, SCAN_RSHIFT); // B still held
        check_eq(int'(key), 98, "lower case after shift release");
        key_release(1'b0, 8'h32);
        key_tap(1'b0, SCAN_CAPS);
        key_tap(1'b0, 8'h21);
        key_press(1'b0, SCAN_LSHIFT);
        key_press(1'b0, 8'h21);
        check_eq(int'(key), 99, "caps with shift");
        key_release(1'b0, 8'h21);
        key_release(1'b0, SCAN_LSHIFT);
        key_press(1'b0, SCAN_CAPS);
        key_press(1'b0, SCAN_CAPS);     // Auto-repeat
        key_release(1'b0, SCAN_CAPS);
        key_tap(1'b0, 8'h21);
        end_scenario("shift and caps");

        for (int i = 0; i < 10; i++) key_tap(1'b1, table_entry(EXT_CODES, 10, i));
        for (int i = 0; i < 10; i++) key_tap(1'b0, table_entry(KEYPAD_CODES, 10, i));
        key_tap(1'b0, 8'h71);
        end_scenario("extended");

        key_press(1'b0, 8'h1c);
        key_press(1'b0, 8'h32);
        key_release(1'b0, 8'h1c);
        check_eq(int'(key), 98, "rollover keeps b");
        key_release(1'b0, 8'h32);
        check_eq(int'(key), 0, "rollover all released");
        key_press(1'b0, SCAN_CAPS);     // Caps on and oldest entry
        key_press(1'b0, 8'h32);
        key_press(1'b0, 8'h21);
        key_press(1'b0, 8'h23);         // Overwrites caps lock
        check_eq(int'(key), 68, "upper case with caps on");
        key_press(1'b0, SCAN_CAPS);     // Toggles only when its slot is gone
        key_press(1'b0, 8'h1c);
        check_eq(int'(key), 97, "caps slot overwritten");
        key_release(1'b0, 8'h1c);
        key_release(1'b0, SCAN_CAPS);
        key_release(1'b0, 8'h32);       // Already overwritten
        key_release(1'b0, 8'h21);
        key_release(1'b0, 8'h23);
        end_scenario("rollover");

        key_press(1'b0, 8'h1c);
        drive_frame(make_frame(8'h32, 1'b1, 1'b0), 11);
        exp_errs++;
        settle();
        check_eq(int'(key), int'(expected_key()), "key after parity error");
        drive_frame(make_frame(8'h32, 1'b0, 1'b1), 11);
        exp_errs++;
        settle();
        check_eq(int'(key), int'(expected_key()), "key after stop bit error");
        drive_frame(make_frame(8'h32, 1'b0, 1'b0), 4);
        tick(PS2_TIMEOUT_CYCLES + 100); // Stalled mid-frame
        settle();
        check_eq(int'(key), int'(expected_key()), "key after stalled frame");
        key_release(1'b0, 8'h1c);
        end_scenario("frame errors");

        for (int ev = 0; ev < 200; ev++) begin
            r   = $random(seed);
            idx = (r & 32'h7fff_ffff) % 38;
            if (idx < 26) code = table_entry(LETTER_CODES, 26, idx);
            else if (idx < 36) code = table_entry(DIGIT_CODES, 10, idx - 26);
            else if (idx == 36) code = SCAN_LSHIFT;
            else code = SCAN_RSHIFT;
            if (r[24]) key_press(1'b0, code);
            else key_release(1'b0, code);
        end
        end_scenario("random");

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
kbd_pkg.sv
ps2_rx.sv
key_tracker.sv
key_map.sv
ps2_keyboard.sv
tb_clk_gen.sv
tb_ps2_keyboard.sv

// ==== Makefile ====
# Verilator build and run of the PS/2 keyboard testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_keyboard
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
